// ==== Bender.yml ====
package:
  name: aexm_core

sources:
  - aexmPkg.sv
  - aexmCreditQueue.sv
  - aexmCtrl.sv
  - aexmRegFile.sv
  - aexmAlu.sv
  - aexmCore.sv
  - target: test
    files:
      - aexmCore_assertions.sv
      - aexmCore_tb.sv

// ==== aexmAlu.sv ====
`timescale 1ns/1ps

module aexmAlu import aexmPkg::*; (
   input  logic        gclk,
   input  logic        grst,
   input  CtrlT        xCtrl,
   input  logic [31:0] opA,
   input  logic [31:0] opB,
   input  logic [15:0] immField,
   output ResultPktT   result,
   output logic        resValid,
   output logic [31:0] fwdData
);

   logic [31:0] aReg;         // Decode operands, captured with xCtrl
   logic [31:0] bReg;
   logic [15:0] immReg;
   logic [15:0] immHi;        // Upper half from an IMM prefix
   logic        immPending;
   logic [31:0] srcVal;
   logic [31:0] altVal;
   logic [31:0] tgtVal;
   logic [31:0] immVal;
   logic [31:0] sum;
   logic [31:0] logicOut;
   logic [31:0] sftOut;
   logic [31:0] aluOut;

   always_ff @(posedge gclk) begin
      aReg   <= opA;
      bReg   <= opB;
      immReg <= immField;
   end

   assign fwdData = result.data;   // Also the write-back data

   assign srcVal = (xCtrl.src == SelFwd) ? fwdData : aReg;
   assign altVal = (xCtrl.alt == SelFwd) ? fwdData : aReg;   // Shift source
   assign immVal = immPending ? {immHi, immReg} : {{16{immReg[15]}}, immReg};

   always_comb begin
      case (xCtrl.tgt)
         SelImm:  tgtVal = immVal;
         SelFwd:  tgtVal = fwdData;
         default: tgtVal = bReg;
      endcase
   end

   assign sum = xCtrl.rsub ? (tgtVal - srcVal) : (srcVal + tgtVal);

   always_comb begin
      case (xCtrl.logicFn)
         LogOr:   logicOut = srcVal | tgtVal;
         LogAnd:  logicOut = srcVal & tgtVal;
         LogXor:  logicOut = srcVal ^ tgtVal;
         LogAndn: logicOut = srcVal & ~tgtVal;
      endcase
   end

   always_comb begin
      case (xCtrl.sftKind)
         SftSra:  sftOut = {altVal[31], altVal[31:1]};
         SftSrc:  sftOut = {1'b0, altVal[31:1]};   // Carry is held at zero
         SftSrl:  sftOut = {1'b0, altVal[31:1]};
         default: sftOut = 32'd0;
      endcase
   end

   always_comb begin
      case (xCtrl.alu)
         AluAdd:  aluOut = sum;
         AluLog:  aluOut = logicOut;
         AluSft:  aluOut = sftOut;
         AluMov:  aluOut = tgtVal;
         default: aluOut = 32'd0;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         immPending <= 1'b0;
         resValid   <= 1'b0;
      end else begin
         resValid <= xCtrl.valid && !xCtrl.isImm;   // Prefixes retire silently
         if (xCtrl.valid) begin
            immPending <= xCtrl.isImm;   // Holds for one instruction
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (xCtrl.valid && xCtrl.isImm) begin
         immHi <= immReg;
      end
      result.rd      <= xCtrl.rw;
      result.data    <= xCtrl.illegal ? 32'd0 : aluOut;
      result.illegal <= xCtrl.illegal;
   end

endmodule

// ==== aexmCore.sv ====
`timescale 1ns/1ps

module aexmCore import aexmPkg::*; (
   input  logic      gclk,
   input  logic      grst,
   input  logic      instrValid,
   input  InstrPktT  instrPkt,
   output logic      instrCredit,
   output logic      resValid,
   output ResultPktT resPkt,
   input  logic      resCredit
);

   InstrPktT           head;
   logic               notEmpty;
   logic               pop;
   logic               canIssue;
   CtrlT               xCtrl;
   logic [4:0]         raSel;
   logic [4:0]         rbSel;
   logic [31:0]        opA;
   logic [31:0]        opB;
   logic [31:0]        fwdData;
   logic [15:0]        dImm;       // Immediate of the word in decode
   logic               wbEn;
   logic               immDone;
   logic [CreditW-1:0] outCredit;
   logic [CreditW-1:0] inFlight;   // Popped but not yet counted against credits

   aexmCreditQueue #(
      .PayloadT (InstrPktT),
      .Depth    (InQueueDepth)
   ) inQueue (
      .gclk     (gclk),
      .grst     (grst),
      .push     (instrValid),
      .pushData (instrPkt),
      .pop      (pop),
      .popData  (head),
      .notEmpty (notEmpty),
      .credit   (instrCredit)
   );

   aexmCtrl ctrl (
      .gclk     (gclk),
      .grst     (grst),
      .head     (head),
      .notEmpty (notEmpty),
      .canIssue (canIssue),
      .pop      (pop),
      .raSel    (raSel),
      .rbSel    (rbSel),
      .xCtrl    (xCtrl)
   );

   always_ff @(posedge gclk) begin
      if (pop) begin
         dImm <= {head.instr.rb, head.instr.alt};
      end
   end

   // Write-back from the result register
   assign wbEn = resValid && !resPkt.illegal && (resPkt.rd != 5'd0);

   aexmRegFile regFile (
      .gclk  (gclk),
      .grst  (grst),
      .raSel (raSel),
      .rbSel (rbSel),
      .opA   (opA),
      .opB   (opB),
      .we    (wbEn),
      .wSel  (resPkt.rd),
      .wData (fwdData)
   );

   aexmAlu alu (
      .gclk     (gclk),
      .grst     (grst),
      .xCtrl    (xCtrl),
      .opA      (opA),
      .opB      (opB),
      .immField (dImm),
      .result   (resPkt),
      .resValid (resValid),
      .fwdData  (fwdData)
   );

   assign immDone  = xCtrl.valid && xCtrl.isImm;
   assign canIssue = (outCredit > inFlight);

   always_ff @(posedge gclk) begin
      if (grst) begin
         outCredit <= CreditW'(OutCredits);
         inFlight  <= '0;
      end else begin
         outCredit <= outCredit - CreditW'(resValid) + CreditW'(resCredit);
         inFlight  <= inFlight + CreditW'(pop) - CreditW'(resValid) - CreditW'(immDone);
      end
   end

endmodule

// ==== aexmCore_assertions.sv ====
`timescale 1ns/1ps

module aexmCore_assertions import aexmPkg::*; (
   input logic               gclk,
   input logic               grst,
   input logic               instrValid,
   input logic               instrCredit,
   input logic               resValid,
   input logic [CreditW-1:0] outCredit
);

   int srcCredits;   // Mirror of the credits held by the source

   always_ff @(posedge gclk) begin
      if (grst) begin
         srcCredits <= InQueueDepth;
      end else begin
         srcCredits <= srcCredits - int'(instrValid) + int'(instrCredit);
      end
   end

   validNeedsCredit: assert property (@(posedge gclk) disable iff (grst)
      instrValid |-> (srcCredits > 0))
      else $error("instrValid raised while the source holds no credit");

   outCreditBounded: assert property (@(posedge gclk) disable iff (grst)
      outCredit <= CreditW'(OutCredits))
      else $error("output credit count went above its initial value");

   // Issue gating means a result never leaves without a credit
   resultHasCredit: assert property (@(posedge gclk) disable iff (grst)
      resValid |-> (outCredit != '0))
      else $error("result sent while the core held no output credit");

endmodule

// ==== aexmCore_tb.sv ====
`timescale 1ns/1ps

module aexmCore_tb import aexmPkg::*; ();

   logic        gclk;
   logic        grst       = 1'b1;
   logic        instrValid = 1'b0;
   InstrPktT    instrPkt   = '0;
   logic        instrCredit;
   logic        resValid;
   ResultPktT   resPkt;
   logic        resCredit  = 1'b0;

   logic [31:0] testMem [256];   // Four words per line of the data file
   InstrPktT    srcWords [$];
   ResultPktT   expPkts [$];
   int          numWords   = 0;
   int          expCount   = 0;
   int          srcIdx     = 0;
   int          srcCredit;
   int          resIdx     = 0;
   int          pending;         // Packets sitting in the sink
   int          holdCnt;
   int          errCount   = 0;
   int          failCount  = 0;
   logic [31:0] lfsrState  = 32'h01b19869;
   logic        sinkPop    = 1'b0;
   ResultPktT   sinkHead;
   logic        sinkNotEmpty;
   logic        consumed;

   aexmCore UUT (
      .gclk        (gclk),
      .grst        (grst),
      .instrValid  (instrValid),
      .instrPkt    (instrPkt),
      .instrCredit (instrCredit),
      .resValid    (resValid),
      .resPkt      (resPkt),
      .resCredit   (resCredit)
   );

   bind aexmCore aexmCore_assertions coreChecks (
      .gclk        (gclk),
      .grst        (grst),
      .instrValid  (instrValid),
      .instrCredit (instrCredit),
      .resValid    (resValid),
      .outCredit   (outCredit)
   );

   // Receive buffer of the sink, sized to the credits it grants
   aexmCreditQueue #(
      .PayloadT (ResultPktT),
      .Depth    (OutCredits)
   ) sinkQueue (
      .gclk     (gclk),
      .grst     (grst),
      .push     (resValid),
      .pushData (resPkt),
      .pop      (sinkPop),
      .popData  (sinkHead),
      .notEmpty (sinkNotEmpty),
      .credit   ()
   );

   function automatic logic [31:0] lfsrStep(input logic [31:0] state);
      return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
   endfunction

   // Four LFSR bits, one step each
   task automatic drawDelay(output int delay);
      delay = 0;
      for (int i = 0; i < 4; i++) begin
         lfsrState = lfsrStep(lfsrState);
         delay = (delay << 1) | int'(lfsrState[0]);
      end
   endtask

   task automatic checkResult(input ResultPktT got, input ResultPktT exp, input int idx);
      if (got !== exp) begin
         errCount++;
         $display("error %0t: packet %0d got rd %0d data %h illegal %b", $time, idx,
                  got.rd, got.data, got.illegal);
         $display("error %0t: packet %0d expected rd %0d data %h illegal %b", $time, idx,
                  exp.rd, exp.data, exp.illegal);
      end
   endtask

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;   // 8 ns period
   end

   // Source side of the instruction link
   always @(posedge gclk) begin
      if (grst) begin
         srcCredit = InQueueDepth;
         srcIdx    = 0;
         instrValid <= 1'b0;
      end else begin
         srcCredit = srcCredit + int'(instrCredit);
         if (srcCredit > 0 && srcIdx < numWords) begin
            instrValid <= 1'b1;
            instrPkt   <= srcWords[srcIdx];
            srcIdx++;
            srcCredit--;   // Spent as the word goes out
         end else begin
            instrValid <= 1'b0;
         end
      end
   end

   // Sink side of the result link
   always @(posedge gclk) begin
      if (grst) begin
         sinkPop   <= 1'b0;
         resCredit <= 1'b0;
         pending   = 0;
         holdCnt   = 30;   // Long initial stall to back up the core
      end else begin
         consumed = sinkPop && sinkNotEmpty;
         pending  = pending + int'(resValid) - int'(consumed);
         if (pending > OutCredits) begin
            failCount++;
            $display("More than %0d result packets outstanding at %0t", OutCredits, $time);
         end
         if (consumed) begin
            if (resIdx < expCount) begin
               checkResult(sinkHead, expPkts[resIdx], resIdx);
               resIdx++;
            end else begin
               failCount++;
               $display("Unexpected extra result packet at %0t", $time);
            end
            drawDelay(holdCnt);
         end else if (holdCnt > 0) begin
            holdCnt--;
         end
         resCredit <= consumed;
         sinkPop   <= (holdCnt == 0);
      end
   end

   initial begin
      ResultPktT expPkt;
      $readmemh("aexmTests.txt", testMem);
      for (int i = 0; i < 64; i++) begin
         if ($isunknown(testMem[4*i]) || testMem[4*i+1] == 32'd3) begin
            break;   // End marker
         end
         srcWords.push_back(InstrPktT'(testMem[4*i]));
         if (testMem[4*i+1] != 32'd0) begin
            expPkt.rd      = testMem[4*i+2][4:0];
            expPkt.data    = testMem[4*i+3];
            expPkt.illegal = (testMem[4*i+1] == 32'd2);
            expPkts.push_back(expPkt);
         end
      end
      expCount = expPkts.size();
      numWords = srcWords.size();
      if (numWords == 0) begin
         failCount++;
         $display("No test words could be read from aexmTests.txt");
      end
      repeat (3) @(posedge gclk);
      grst <= 1'b0;
      wait (resIdx == expCount);
      repeat (20) @(posedge gclk);   // Room for stray packets
      $display("Packets checked: %0d of %0d, errors: %0d, other failures: %0d",
               resIdx, expCount, errCount, failCount);
      if (errCount == 0 && failCount == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   // Watchdog, 40 cycles per test word
   initial begin
      wait (numWords > 0);
      repeat (numWords * 40 + 3) @(posedge gclk);
      $display("Timeout: %0d of %0d result packets arrived within %0d cycles",
               resIdx, expCount, numWords * 40);
      $display("Test failures found");
      $finish;
   end

endmodule

// ==== aexmCreditQueue.sv ====
`timescale 1ns/1ps

module aexmCreditQueue #(
   parameter type PayloadT = logic [31:0],
   parameter int  Depth    = 4
) (
   input  logic    gclk,
   input  logic    grst,
   input  logic    push,
   input  PayloadT pushData,
   input  logic    pop,
   output PayloadT popData,
   output logic    notEmpty,
   output logic    credit
);

   PayloadT                    mem [Depth];
   logic [$clog2(Depth)-1:0]   wrPtr;
   logic [$clog2(Depth)-1:0]   rdPtr;
   logic [$clog2(Depth+1)-1:0] count;
   logic                       doPop;

   // Circular pointer step
   function automatic logic [$clog2(Depth)-1:0] nextPtr(input logic [$clog2(Depth)-1:0] ptr);
      return (int'(ptr) == Depth - 1) ? '0 : ptr + 1'b1;
   endfunction

   assign notEmpty = (count != '0);
   assign doPop    = pop && notEmpty;
   assign popData  = mem[rdPtr];   // Head word

   always_ff @(posedge gclk) begin
      if (push) begin
         mem[wrPtr] <= pushData;
      end
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         wrPtr  <= '0;
         rdPtr  <= '0;
         count  <= '0;
         credit <= 1'b0;
      end else begin
         credit <= doPop;   // One credit back per word consumed
         if (push) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (doPop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         case ({push, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== aexmCtrl.sv ====
`timescale 1ns/1ps

module aexmCtrl import aexmPkg::*; (
   input  logic       gclk,
   input  logic       grst,
   input  InstrPktT   head,
   input  logic       notEmpty,
   input  logic       canIssue,
   output logic       pop,
   output logic [4:0] raSel,
   output logic [4:0] rbSel,
   output CtrlT       xCtrl
);

   InstrT      dInstr;     // Word in decode
   logic       dValid;
   logic [5:0] opcBase;    // Opcode without the immediate bit
   logic       isAdd;
   logic       isLog;
   logic       isSft;
   logic       isImm;
   logic       isIllegal;
   logic       xWrites;
   logic       aFwd;
   logic       bFwd;
   CtrlT       dCtrl;

   assign pop = notEmpty && canIssue;

   always_ff @(posedge gclk) begin
      if (grst) begin
         dValid <= 1'b0;
      end else begin
         dValid <= pop;
      end
   end

   always_ff @(posedge gclk) begin
      if (pop) begin
         dInstr <= head.instr;
      end
   end

   // Register file is read during decode
   assign raSel = dInstr.ra;
   assign rbSel = dInstr.rb;

   // Opcode groups
   assign opcBase   = dInstr.opcode & 6'o67;
   assign isAdd     = (opcBase == OpAdd) || (opcBase == OpRsub);
   assign isLog     = opcBase inside {OpOr, OpAnd, OpXor, OpAndn};
   assign isImm     = (dInstr.opcode == OpImm);
   assign isSft     = (dInstr.opcode == OpShift) && dInstr.alt[0]
                      && (dInstr.alt[6:5] inside {SftSra, SftSrc, SftSrl});
   assign isIllegal = !(isAdd || isLog || isSft || isImm);

   // Forward from the instruction now in execute
   assign xWrites = xCtrl.valid && (xCtrl.rw != 5'd0);
   assign aFwd    = xWrites && (xCtrl.rw == dInstr.ra);
   assign bFwd    = xWrites && (xCtrl.rw == dInstr.rb);

   always_comb begin
      dCtrl.src = aFwd ? SelFwd : SelReg;
      dCtrl.alt = aFwd ? SelFwd : SelReg;
      if (dInstr.opcode[3]) begin
         dCtrl.tgt = SelImm;
      end else if (bFwd) begin
         dCtrl.tgt = SelFwd;
      end else begin
         dCtrl.tgt = SelReg;
      end

      if (isImm) begin
         dCtrl.alu = AluMov;
      end else if (isSft) begin
         dCtrl.alu = AluSft;
      end else if (isLog) begin
         dCtrl.alu = AluLog;
      end else begin
         dCtrl.alu = AluAdd;
      end

      dCtrl.rw      = (isImm || isIllegal) ? 5'd0 : dInstr.rd;   // Skipped words never write
      dCtrl.valid   = dValid;
      dCtrl.illegal = isIllegal;
      dCtrl.isImm   = isImm;
      dCtrl.rsub    = isAdd && dInstr.opcode[0];
      dCtrl.logicFn = dInstr.opcode[1:0];
      dCtrl.sftKind = dInstr.alt[6:5];
   end

   // Delay register into execute
   always_ff @(posedge gclk) begin
      if (grst) begin
         xCtrl <= '0;
      end else begin
         xCtrl <= dCtrl;
      end
   end

endmodule

// ==== aexmPkg.sv ====
package aexmPkg;

   // Opcodes in octal, bit 3 set gives the immediate form
   localparam logic [5:0] OpAdd   = 6'o00;
   localparam logic [5:0] OpRsub  = 6'o01;
   localparam logic [5:0] OpOr    = 6'o40;
   localparam logic [5:0] OpAnd   = 6'o41;
   localparam logic [5:0] OpXor   = 6'o42;
   localparam logic [5:0] OpAndn  = 6'o43;
   localparam logic [5:0] OpShift = 6'o44;
   localparam logic [5:0] OpImm   = 6'o54;

   // Operand selects
   localparam logic [1:0] SelReg = 2'd0;
   localparam logic [1:0] SelFwd = 2'd1;
   localparam logic [1:0] SelImm = 2'd3;   // Target only

   // ALU function
   localparam logic [2:0] AluAdd = 3'd0;
   localparam logic [2:0] AluLog = 3'd1;
   localparam logic [2:0] AluSft = 3'd2;
   localparam logic [2:0] AluMov = 3'd3;

   // Logic function, taken from opcode bits 1:0
   localparam logic [1:0] LogOr   = 2'd0;
   localparam logic [1:0] LogAnd  = 2'd1;
   localparam logic [1:0] LogXor  = 2'd2;
   localparam logic [1:0] LogAndn = 2'd3;

   // Shift kind, taken from alt bits 6:5
   localparam logic [1:0] SftSra = 2'd0;
   localparam logic [1:0] SftSrc = 2'd1;
   localparam logic [1:0] SftSrl = 2'd2;

   localparam int InQueueDepth = 4;
   localparam int OutCredits   = 4;
   localparam int CreditW      = $clog2(OutCredits + 1);

   typedef logic [1:0] SrcSelT;
   typedef logic [1:0] TgtSelT;
   typedef logic [1:0] AltSelT;
   typedef logic [2:0] AluSelT;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rd;
      logic [4:0]  ra;
      logic [4:0]  rb;
      logic [10:0] alt;
   } InstrT;

   typedef struct packed {
      InstrT instr;
   } InstrPktT;

   typedef struct packed {
      logic [4:0]  rd;
      logic [31:0] data;
      logic        illegal;
   } ResultPktT;

   // Control handed from decode to execute
   typedef struct packed {
      SrcSelT     src;
      TgtSelT     tgt;
      AltSelT     alt;
      AluSelT     alu;
      logic [4:0] rw;        // Zero means no write
      logic       valid;
      logic       illegal;
      logic       isImm;
      logic       rsub;
      logic [1:0] logicFn;
      logic [1:0] sftKind;
   } CtrlT;

endpackage

// ==== aexmRegFile.sv ====
`timescale 1ns/1ps

module aexmRegFile (
   input  logic        gclk,
   input  logic        grst,
   input  logic [4:0]  raSel,
   input  logic [4:0]  rbSel,
   output logic [31:0] opA,
   output logic [31:0] opB,
   input  logic        we,
   input  logic [4:0]  wSel,
   input  logic [31:0] wData
);

   logic [31:0] regs [32];
   logic        wLive;   // Write that really lands

   assign wLive = we && (wSel != 5'd0);

   always_ff @(posedge gclk) begin
      if (grst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= 32'd0;
         end
      end else if (wLive) begin
         regs[wSel] <= wData;
      end
   end

   // Write-first bypass on both read ports
   always_comb begin
      if (wLive && (wSel == raSel)) begin
         opA = wData;
      end else begin
         opA = regs[raSel];
      end
   end

   always_comb begin
      if (wLive && (wSel == rbSel)) begin
         opB = wData;
      end else begin
         opB = regs[rbSel];
      end
   end

endmodule

// ==== aexmTests.txt ====
// Columns: instruction word, kind (0 no packet, 1 result, 2 illegal, 3 end), rd, data
// All values hex; registers are loaded by add-immediate from r0
20201234 1 01 00001234 // addi r1, r0, 0x1234
2040fffb 1 02 fffffffb // addi r2, r0, -5
20600f0f 1 03 00000f0f // addi r3, r0, 0x0f0f
00811000 1 04 0000122f // add r4, r1, r2
04a11000 1 05 ffffedc7 // rsub r5, r1, r2
24c30100 1 06 fffff1f1 // rsubi r6, r3, 0x0100
80e11800 1 07 00001f3f // or r7, r1, r3
85011800 1 08 00000204 // and r8, r1, r3
89211800 1 09 00001d3b // xor r9, r1, r3
8d411800 1 0a 00001030 // andn r10, r1, r3
a1637000 1 0b 00007f0f // ori r11, r3, 0x7000
a5828001 1 0c ffff8001 // andi r12, r2, 0x8001
a9a1ffff 1 0d ffffedcb // xori r13, r1, 0xffff
adc10030 1 0e 00001204 // andni r14, r1, 0x0030
91e20001 1 0f fffffffd // sra r15, r2
91e20021 1 0f 7ffffffd // src r15, r2
91e20041 1 0f 7ffffffd // srl r15, r2
92010001 1 10 0000091a // sra r16, r1
92030021 1 10 00000787 // src r16, r3
92030041 1 10 00000787 // srl r16, r3
b000dead 0 00 00000000 // imm 0xdead
2220beef 1 11 deadbeef // addi r17, r0, 0xbeef
22510001 1 12 deadbef0 // addi r18, r17, 1
02729000 1 13 bd5b7de0 // add r19, r18, r18
06919800 1 14 deadbef1 // rsub r20, r17, r19
40811000 2 00 00000000 // mul r4, r1, r2 is not supported
82a40000 1 15 0000122f // or r21, r4, r0
00000000 3 00 00000000 // end of tests

// ==== files.f ====
aexmPkg.sv
aexmCreditQueue.sv
aexmCtrl.sv
aexmRegFile.sv
aexmAlu.sv
aexmCore.sv
aexmCore_assertions.sv
aexmCore_tb.sv
